// ==== cpu_core.f ====
+incdir+src
src/cpu_pkg.sv
src/cpu_decode.sv
src/cpu_execute.sv
src/cpu_writeback.sv
src/cpu_core.sv
tests/cpu_core_properties.sv
tests/tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
  -f cpu_core.f --top-module tb_cpu_core -o vtb_cpu_core
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/vtb_cpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  exit 1
fi

exit 0

// ==== tests/tb_cpu_core.sv ====
/*
  testbench for cpu_core
  instruction and data memory models, directed tests,
  watchdog and closing summary
*/
`include "cpu_consts.svh"

module tb_cpu_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 40;
  localparam int MEM_WORDS   = 2048;
  // instruction count of all tests rounded up
  localparam int TOTAL_INSTR = 100;
  // slowest memory answer in cycles
  localparam int WORST_LAT   = 4;
  localparam int WATCHDOG_NS = (TOTAL_INSTR * WORST_LAT * 10 + 100) * CLK_PERIOD;

  // opcodes as the ISA defines them
  localparam logic [2:0] OPC_ARITH  = 3'b000;
  localparam logic [2:0] OPC_CMPMUL = 3'b001;
  localparam logic [2:0] OPC_LOAD   = 3'b010;
  localparam logic [2:0] OPC_STORE  = 3'b011;
  localparam logic [2:0] OPC_BEQ    = 3'b100;

  logic                    clk;
  logic                    rst_n;
  logic                    inst_req;
  logic [`CPU_PC_W-1:0]    inst_addr;
  logic                    inst_valid;
  logic [`CPU_DATA_W-1:0]  inst_data;
  logic                    mem_rd;
  logic                    mem_wr;
  logic [`CPU_PC_W-1:0]    mem_addr;
  logic [`CPU_DATA_W-1:0]  mem_wdata;
  logic                    mem_ack;
  logic [`CPU_DATA_W-1:0]  mem_rdata;
  logic                    io_stall;

  logic [`CPU_DATA_W-1:0]  imem [MEM_WORDS];
  logic [`CPU_DATA_W-1:0]  dmem [MEM_WORDS];
  int                      st_addr [$];
  int                      st_data [$];
  int                      exp_addr [$];
  int                      exp_data [$];
  int                      fetch_log [$];
  int                      err_cnt;
  int                      check_cnt;
  bit                      rand_lat;

  cpu_core i_cpu_core (.*);

  // ##########################################################
  // clock and watchdog
  // ##########################################################
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run did not reach its end");
    $display("Test failures found");
    $finish;
  end

  // ##########################################################
  // memory models
  // ##########################################################
  function automatic int pick_latency();
    return rand_lat ? 1 + int'($urandom % WORST_LAT) : 1;
  endfunction

  // instruction port answers a held inst_req after the latency
  initial begin
    int lat;
    forever begin
      @(posedge clk);
      #1;
      if (inst_req) begin
        lat = pick_latency();
        repeat (lat - 1) @(posedge clk);
        if (lat > 1) #1;
        fetch_log.push_back(int'(inst_addr));
        inst_data  = imem[inst_addr];
        inst_valid = 1'b1;
        @(posedge clk);
        #1 inst_valid = 1'b0;
      end
    end
  end

  // data port logs stores in order
  initial begin
    int lat;
    forever begin
      @(posedge clk);
      #1;
      if (mem_rd || mem_wr) begin
        lat = pick_latency();
        repeat (lat - 1) @(posedge clk);
        if (lat > 1) #1;
        if (mem_wr) begin
          st_addr.push_back(int'(mem_addr));
          st_data.push_back(int'(mem_wdata));
          dmem[mem_addr] = mem_wdata;
        end else begin
          mem_rdata = dmem[mem_addr];
        end
        mem_ack = 1'b1;
        @(posedge clk);
        #1 mem_ack = 1'b0;
      end
    end
  end

  // ##########################################################
  // instruction encoders
  // ##########################################################
  function automatic logic [15:0] enc_reg(input logic [2:0] op, input int rs, input int rt,
                                          input int rd, input logic func);
    return {op, 4'(rs), 4'(rt), 4'(rd), func};
  endfunction

  function automatic logic [15:0] enc_imm(input logic [2:0] op, input int rs, input int rt,
                                          input int imm);
    return {op, 4'(rs), 4'(rt), 5'(imm)};
  endfunction

  function automatic logic [15:0] enc_jump(input int target);
    return {3'b101, 1'b0, 11'(target), 1'b0};
  endfunction

  // ##########################################################
  // helpers
  // ##########################################################
  // data fill differs at every address
  // unused code jumps to itself
  task automatic clear_mems();
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = enc_jump(i);
      dmem[i] = 16'(i * 16'h9e37) ^ 16'h5a5a;
    end
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic expect_store(input int addr, input int data);
    exp_addr.push_back(addr);
    exp_data.push_back(data & 16'hffff);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    #1 rst_n = 1'b0;
    repeat (8) @(posedge clk);
    // logs cleared once any fetch left over from the last test is gone
    st_addr.delete();
    st_data.delete();
    fetch_log.delete();
    #1 rst_n = 1'b1;
  endtask

  // runs to the halt fetch and counts io_stall low cycles
  task automatic run_to_halt(input int halt, output int stall_lows);
    bit first;
    first      = 1'b1;
    stall_lows = 0;
    forever begin
      @(posedge clk);
      #1;
      if (!io_stall) stall_lows++;
      if (inst_req && first) begin
        first = 1'b0;
        check_cnt++;
        if (inst_addr != 0) begin
          err_cnt++;
          $display("FAIL @%0t: first inst_addr %0d, expected 0", $time, inst_addr);
        end
      end
      if (inst_req && (int'(inst_addr) == halt)) break;
    end
  endtask

  task automatic compare_stores(input string name);
    check_cnt++;
    if (st_addr.size() != exp_addr.size()) begin
      err_cnt++;
      $display("FAIL @%0t: %s saw %0d stores, expected %0d", $time, name,
               st_addr.size(), exp_addr.size());
    end else begin
      foreach (exp_addr[i]) begin
        if ((st_addr[i] != exp_addr[i]) || (st_data[i] != exp_data[i])) begin
          err_cnt++;
          $display("FAIL @%0t: %s store %0d at %0h data %0h, expected %0h data %0h",
                   $time, name, i, st_addr[i], st_data[i], exp_addr[i], exp_data[i]);
        end
      end
    end
  endtask

  task automatic compare_fetches(input string name, input int exp_q [$]);
    check_cnt++;
    if (fetch_log.size() < exp_q.size()) begin
      err_cnt++;
      $display("FAIL @%0t: %s fetched %0d words, expected at least %0d", $time, name,
               fetch_log.size(), exp_q.size());
    end else begin
      foreach (exp_q[i]) begin
        if (fetch_log[i] != exp_q[i]) begin
          err_cnt++;
          $display("FAIL @%0t: %s fetch %0d at %0d, expected %0d", $time, name, i,
                   fetch_log[i], exp_q[i]);
        end
      end
    end
  endtask

  // two loads, four ALU ops, four stores, halt at 10
  task automatic load_arith(input logic [15:0] a, input logic [15:0] b);
    logic signed [15:0] sa;
    logic signed [15:0] sb;
    logic signed [31:0] prod;
    sa = a;
    sb = b;
    prod = sa * sb;
    clear_mems();
    dmem[0] = a;
    dmem[1] = b;
    imem[0]  = enc_imm(OPC_LOAD, 0, 1, 0);
    imem[1]  = enc_imm(OPC_LOAD, 0, 2, 1);
    imem[2]  = enc_reg(OPC_ARITH, 1, 2, 3, 1'b0);
    imem[3]  = enc_reg(OPC_ARITH, 1, 2, 4, 1'b1);
    imem[4]  = enc_reg(OPC_CMPMUL, 1, 2, 5, 1'b0);
    imem[5]  = enc_reg(OPC_CMPMUL, 1, 2, 6, 1'b1);
    for (int r = 3; r <= 6; r++) begin
      imem[r + 3] = enc_imm(OPC_STORE, 0, r, r - 1);
    end
    imem[10] = enc_jump(10);
    expect_store(2, int'(a) + int'(b));
    expect_store(3, int'(a) - int'(b));
    expect_store(4, (sa < sb) ? 1 : 0);
    expect_store(5, int'(prod[15:0]));
  endtask

  // ##########################################################
  // directed tests
  // ##########################################################
  task automatic test_reset();
    int lows;
    clear_mems();
    for (int r = 0; r < 16; r++) begin
      imem[r] = enc_imm(OPC_STORE, 0, r, r);
      expect_store(r, 0);
    end
    imem[16] = enc_jump(16);
    reset_dut();
    run_to_halt(16, lows);
    compare_stores("reset");
  endtask

  task automatic test_arith();
    int lows;
    for (int k = 0; k < 3; k++) begin
      load_arith(16'($urandom), 16'($urandom));
      reset_dut();
      run_to_halt(10, lows);
      compare_stores("arith");
    end
  endtask

  task automatic test_memory();
    int lows;
    clear_mems();
    dmem[0]    = 16'd16;
    dmem[1]    = 16'd2;
    dmem[13]   = 16'hbeef;
    dmem[2046] = 16'h1234;
    imem[0] = enc_imm(OPC_LOAD, 0, 1, 0);
    imem[1] = enc_imm(OPC_LOAD, 1, 2, -3);
    imem[2] = enc_imm(OPC_STORE, 1, 2, 15);
    imem[3] = enc_imm(OPC_LOAD, 0, 3, 1);
    // negative offsets below zero wrap to the top of memory
    imem[4] = enc_imm(OPC_STORE, 3, 2, -5);
    imem[5] = enc_imm(OPC_LOAD, 3, 4, -4);
    imem[6] = enc_imm(OPC_STORE, 0, 4, 7);
    imem[7] = enc_jump(7);
    expect_store(31, 16'hbeef);
    expect_store(2045, 16'hbeef);
    expect_store(7, 16'h1234);
    reset_dut();
    run_to_halt(7, lows);
    compare_stores("memory");
  endtask

  task automatic test_branch();
    int lows;
    int exp_q [$];
    clear_mems();
    dmem[0] = 16'd5;
    imem[0]  = enc_imm(OPC_BEQ, 0, 0, 2);
    imem[3]  = enc_imm(OPC_LOAD, 0, 1, 0);
    imem[4]  = enc_imm(OPC_BEQ, 0, 1, 5);
    imem[5]  = enc_imm(OPC_BEQ, 1, 1, 1);
    imem[7]  = enc_imm(OPC_BEQ, 0, 0, -7);
    imem[1]  = enc_jump(10);
    imem[10] = enc_jump(10);
    exp_q = '{0, 3, 4, 5, 7, 1};
    reset_dut();
    run_to_halt(10, lows);
    compare_fetches("branch", exp_q);
  endtask

  task automatic test_jump();
    int lows;
    int exp_q [$];
    clear_mems();
    imem[0]    = enc_jump(100);
    imem[100]  = enc_jump(2000);
    imem[2000] = enc_jump(5);
    exp_q = '{0, 100, 2000};
    reset_dut();
    run_to_halt(5, lows);
    compare_fetches("jump", exp_q);
  endtask

  task automatic test_latency();
    int lows;
    rand_lat = 1'b1;
    for (int k = 0; k < 2; k++) begin
      load_arith(16'($urandom), 16'($urandom));
      reset_dut();
      run_to_halt(10, lows);
      compare_stores("latency");
      check_cnt++;
      // ten instructions retire before the halt fetch
      if (lows != 10) begin
        err_cnt++;
        $display("FAIL @%0t: %0d io_stall low cycles, expected 10", $time, lows);
      end
    end
    rand_lat = 1'b0;
  endtask

  // ##########################################################
  // main sequence
  // ##########################################################
  initial begin
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst_data  = '0;
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    rand_lat   = 1'b0;
    err_cnt    = 0;
    check_cnt  = 0;
    void'($urandom(32'h2c4c57a3));
    // arithmetic first so the reset test starts from dirty registers
    test_arith();
    test_reset();
    test_memory();
    test_branch();
    test_jump();
    test_latency();
    $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== tests/cpu_core_properties.sv ====
/*
  concurrent checks on the cpu_core memory strobes
  and on the stall flag, bound into every cpu_core
*/
`include "cpu_consts.svh"

module cpu_core_properties (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  inst_req,
  input logic                  mem_rd,
  input logic                  mem_wr,
  input logic [`CPU_PC_W-1:0]  mem_addr,
  input logic                  mem_ack,
  input logic                  io_stall
);
  timeunit 1ns;
  timeprecision 1ps;

  // ##########################################################
  // strobe exclusion
  // ##########################################################
  // read and write strobes are one-hot or idle
  rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_rd && mem_wr))
    else $error("mem_rd and mem_wr high together");

  // fetch and data access never overlap
  fetch_data_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !((mem_rd || mem_wr) && inst_req))
    else $error("data strobe high together with inst_req");

  // ##########################################################
  // handshake and stall
  // ##########################################################
  // address held while the access waits for its ack
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ((mem_rd || mem_wr) && !mem_ack) |=> $stable(mem_addr))
    else $error("mem_addr changed while waiting for mem_ack");

  // at most one retire per cycle pair
  stall_single_low: assert property (@(posedge clk) disable iff (!rst_n)
    !io_stall |=> io_stall)
    else $error("io_stall low on two cycles in a row");

endmodule

bind cpu_core cpu_core_properties i_cpu_core_properties (.*);

// ==== src/cpu_core.sv ====
/*
  top level of the multicycle core
  decode, execute and writeback on plain memory ports
*/
`include "cpu_consts.svh"

module cpu_core (
  input  logic                    clk,
  input  logic                    rst_n,
  // instruction port
  output logic                    inst_req,
  output logic [`CPU_PC_W-1:0]    inst_addr,
  input  logic                    inst_valid,
  input  logic [`CPU_DATA_W-1:0]  inst_data,
  // data port
  output logic                    mem_rd,
  output logic                    mem_wr,
  output logic [`CPU_PC_W-1:0]    mem_addr,
  output logic [`CPU_DATA_W-1:0]  mem_wdata,
  input  logic                    mem_ack,
  input  logic [`CPU_DATA_W-1:0]  mem_rdata,
  // low one cycle per retired instruction
  output logic                    io_stall
);

  // ##########################################################
  // inner wires
  // ##########################################################
  // decode to execute
  logic                       operand_load;
  cpu_pkg::alu_op_e           alu_op;
  logic [`CPU_DATA_W-1:0]     imm;
  logic                       use_imm;
  // decode to writeback
  logic [`CPU_REG_IDX_W-1:0]  rs_idx;
  logic [`CPU_REG_IDX_W-1:0]  rt_idx;
  logic                       wb_en;
  logic [`CPU_REG_IDX_W-1:0]  wb_idx;
  logic                       wb_load;
  // register reads and results
  logic [`CPU_DATA_W-1:0]     rs_val;
  logic [`CPU_DATA_W-1:0]     rt_val;
  logic [`CPU_DATA_W-1:0]     alu_result;
  logic                       branch_equal;

  cpu_decode i_cpu_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst_data    (inst_data),
    .mem_ack      (mem_ack),
    .branch_equal (branch_equal),
    .inst_req     (inst_req),
    .inst_addr    (inst_addr),
    .mem_rd       (mem_rd),
    .mem_wr       (mem_wr),
    .operand_load (operand_load),
    .alu_op       (alu_op),
    .imm          (imm),
    .use_imm      (use_imm),
    .rs_idx       (rs_idx),
    .rt_idx       (rt_idx),
    .wb_en        (wb_en),
    .wb_idx       (wb_idx),
    .wb_load      (wb_load),
    .io_stall     (io_stall)
  );

  cpu_execute i_cpu_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .operand_load (operand_load),
    .alu_op       (alu_op),
    .imm          (imm),
    .use_imm      (use_imm),
    .rs_val       (rs_val),
    .rt_val       (rt_val),
    .alu_result   (alu_result),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .branch_equal (branch_equal)
  );

  cpu_writeback i_cpu_writeback (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs_idx     (rs_idx),
    .rt_idx     (rt_idx),
    .wb_en      (wb_en),
    .wb_idx     (wb_idx),
    .wb_load    (wb_load),
    .alu_result (alu_result),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .rs_val     (rs_val),
    .rt_val     (rt_val)
  );

endmodule

// ==== src/cpu_writeback.sv ====
/*
  register file, two combinational read ports
  load data latch and register write select
*/
`include "cpu_consts.svh"

module cpu_writeback (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`CPU_REG_IDX_W-1:0]  rs_idx,
  input  logic [`CPU_REG_IDX_W-1:0]  rt_idx,
  input  logic                       wb_en,
  input  logic [`CPU_REG_IDX_W-1:0]  wb_idx,
  input  logic                       wb_load,
  input  logic [`CPU_DATA_W-1:0]     alu_result,
  input  logic                       mem_ack,
  input  logic [`CPU_DATA_W-1:0]     mem_rdata,
  output logic [`CPU_DATA_W-1:0]     rs_val,
  output logic [`CPU_DATA_W-1:0]     rt_val
);

  logic signed [`CPU_DATA_W-1:0] regs [`CPU_REG_CNT];
  logic [`CPU_DATA_W-1:0]        load_q;
  logic [`CPU_DATA_W-1:0]        wb_data;

  // ##########################################################
  // load latch
  // ##########################################################
  // rdata only valid with the ack pulse
  always_ff @(posedge clk) begin
    if (mem_ack) begin
      load_q <= mem_rdata;
    end
  end

  assign wb_data = wb_load ? load_q : alu_result;

  // ##########################################################
  // register file
  // ##########################################################
  // all sixteen clear to zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_idx] <= wb_data;
    end
  end

  // read ports, sampled by execute at end of decode
  assign rs_val = regs[rs_idx];
  assign rt_val = regs[rt_idx];

endmodule

// ==== src/cpu_execute.sv ====
/*
  operand latches and ALU with registered result
  data memory address, write data, branch compare
*/
`include "cpu_consts.svh"

module cpu_execute (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    operand_load,
  input  cpu_pkg::alu_op_e        alu_op,
  input  logic [`CPU_DATA_W-1:0]  imm,
  input  logic                    use_imm,
  input  logic [`CPU_DATA_W-1:0]  rs_val,
  input  logic [`CPU_DATA_W-1:0]  rt_val,
  output logic [`CPU_DATA_W-1:0]  alu_result,
  output logic [`CPU_PC_W-1:0]    mem_addr,
  output logic [`CPU_DATA_W-1:0]  mem_wdata,
  output logic                    branch_equal
);

  logic [`CPU_DATA_W-1:0]        rs_q;
  logic [`CPU_DATA_W-1:0]        rt_q;
  logic [`CPU_DATA_W-1:0]        opnd_b;
  logic [`CPU_DATA_W-1:0]        sum;
  logic [`CPU_DATA_W-1:0]        diff;
  logic signed [`CPU_DATA_W-1:0] prod;
  logic                          slt;
  logic [`CPU_DATA_W-1:0]        alu_nxt;
  logic                          exec_cycle;

  // ##########################################################
  // operand latches
  // ##########################################################
  // captured at the end of decode, held until the next decode
  always_ff @(posedge clk) begin
    if (operand_load) begin
      rs_q <= rs_val;
      rt_q <= rt_val;
    end
  end

  // marks the execute cycle, one after decode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exec_cycle <= 1'b0;
    end else begin
      exec_cycle <= operand_load;
    end
  end

  // ##########################################################
  // ALU
  // ##########################################################
  // second adder input is the immediate for memory ops
  assign opnd_b = use_imm ? imm : rt_q;
  assign sum    = rs_q + opnd_b;
  assign diff   = rs_q - rt_q;
  // truncated to the low half of the signed product
  assign prod   = $signed(rs_q) * $signed(rt_q);
  assign slt    = $signed(rs_q) < $signed(rt_q);

  always_comb begin
    case (alu_op)
      cpu_pkg::ALU_SUB: alu_nxt = diff;
      cpu_pkg::ALU_SLT: alu_nxt = {{(`CPU_DATA_W-1){1'b0}}, slt};
      cpu_pkg::ALU_MUL: alu_nxt = prod;
      default:          alu_nxt = sum;
    endcase
  end

  // result held through writeback
  always_ff @(posedge clk) begin
    if (exec_cycle) begin
      alu_result <= alu_nxt;
    end
  end

  // ##########################################################
  // memory and branch
  // ##########################################################
  // word address is the low bits of rs + imm, wraps mod 2^11
  assign mem_addr     = sum[`CPU_PC_W-1:0];
  assign mem_wdata    = rt_q;
  assign branch_equal = (rs_q == rt_q);

endmodule

// ==== src/cpu_decode.sv ====
/*
  control FSM, program counter and instruction register
  field split, ALU select and strobes
  instruction port, data strobes and stall flag
*/
`include "cpu_consts.svh"

module cpu_decode (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        inst_valid,
  input  logic [`CPU_DATA_W-1:0]      inst_data,
  input  logic                        mem_ack,
  input  logic                        branch_equal,
  output logic                        inst_req,
  output logic [`CPU_PC_W-1:0]        inst_addr,
  output logic                        mem_rd,
  output logic                        mem_wr,
  output logic                        operand_load,
  output cpu_pkg::alu_op_e            alu_op,
  output logic [`CPU_DATA_W-1:0]      imm,
  output logic                        use_imm,
  output logic [`CPU_REG_IDX_W-1:0]   rs_idx,
  output logic [`CPU_REG_IDX_W-1:0]   rt_idx,
  output logic                        wb_en,
  output logic [`CPU_REG_IDX_W-1:0]   wb_idx,
  output logic                        wb_load,
  output logic                        io_stall
);

  cpu_pkg::state_e             state;
  cpu_pkg::state_e             state_nxt;
  cpu_pkg::opcode_e            opcode;
  logic [`CPU_PC_W-1:0]        pc;
  logic [`CPU_DATA_W-1:0]      ir;
  logic                        func;
  logic [`CPU_REG_IDX_W-1:0]   rd_idx;
  logic [`CPU_PC_W-1:0]        jmp_target;
  logic                        retire;

  // ##########################################################
  // field split
  // ##########################################################
  assign opcode     = cpu_pkg::opcode_e'(ir[`CPU_OP_MSB:`CPU_OP_LSB]);
  // func is the lowest bit, shared with the immediate
  assign func       = ir[0];
  assign rs_idx     = ir[`CPU_RS_LSB +: `CPU_REG_IDX_W];
  assign rt_idx     = ir[`CPU_RT_LSB +: `CPU_REG_IDX_W];
  assign rd_idx     = ir[`CPU_RD_LSB +: `CPU_REG_IDX_W];
  assign jmp_target = ir[`CPU_JMP_LSB +: `CPU_PC_W];
  // 5-bit immediate, sign extended to the data width
  assign imm = {{(`CPU_DATA_W-`CPU_IMM_W){ir[`CPU_IMM_W-1]}}, ir[`CPU_IMM_W-1:0]};

  // memory ops add the immediate instead of rt
  assign use_imm = (opcode == cpu_pkg::OP_LOAD) || (opcode == cpu_pkg::OP_STORE);
  // LOAD writes rt from the load latch, ALU ops write rd
  assign wb_load = (opcode == cpu_pkg::OP_LOAD);
  assign wb_idx  = wb_load ? rt_idx : rd_idx;

  always_comb begin
    case (opcode)
      cpu_pkg::OP_ARITH:  alu_op = func ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
      cpu_pkg::OP_CMPMUL: alu_op = func ? cpu_pkg::ALU_MUL : cpu_pkg::ALU_SLT;
      // address adds for LOAD and STORE
      default:            alu_op = cpu_pkg::ALU_ADD;
    endcase
  end

  // per-state strobes to execute and writeback
  assign operand_load = (state == cpu_pkg::ST_DECODE);
  assign wb_en        = (state == cpu_pkg::ST_WRITEBACK);
  assign inst_addr    = pc;

  // ##########################################################
  // control FSM
  // ##########################################################
  always_comb begin
    state_nxt = state;
    case (state)
      cpu_pkg::ST_FETCH: begin
        if (inst_valid) begin
          state_nxt = cpu_pkg::ST_DECODE;
        end
      end
      cpu_pkg::ST_DECODE: begin
        case (opcode)
          cpu_pkg::OP_ARITH, cpu_pkg::OP_CMPMUL, cpu_pkg::OP_LOAD,
          cpu_pkg::OP_STORE, cpu_pkg::OP_BEQ: state_nxt = cpu_pkg::ST_EXECUTE;
          // JUMP done here, unused opcodes skipped
          default: state_nxt = cpu_pkg::ST_FETCH;
        endcase
      end
      cpu_pkg::ST_EXECUTE: begin
        case (opcode)
          cpu_pkg::OP_BEQ:                   state_nxt = cpu_pkg::ST_FETCH;
          cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE: state_nxt = cpu_pkg::ST_MEMORY;
          default:                           state_nxt = cpu_pkg::ST_WRITEBACK;
        endcase
      end
      cpu_pkg::ST_MEMORY: begin
        // wait for the ack, a store is finished with it
        if (mem_ack) begin
          if (opcode == cpu_pkg::OP_STORE) begin
            state_nxt = cpu_pkg::ST_FETCH;
          end else begin
            state_nxt = cpu_pkg::ST_WRITEBACK;
          end
        end
      end
      default: state_nxt = cpu_pkg::ST_FETCH;
    endcase
  end

  // any return to fetch retires one instruction
  assign retire = (state != cpu_pkg::ST_FETCH) && (state_nxt == cpu_pkg::ST_FETCH);

  // strobes registered from the next state, so they track the state exactly
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= cpu_pkg::ST_FETCH;
      inst_req <= 1'b0;
      mem_rd   <= 1'b0;
      mem_wr   <= 1'b0;
      io_stall <= 1'b1;
    end else begin
      state    <= state_nxt;
      inst_req <= (state_nxt == cpu_pkg::ST_FETCH);
      mem_rd   <= (state_nxt == cpu_pkg::ST_MEMORY) && (opcode == cpu_pkg::OP_LOAD);
      mem_wr   <= (state_nxt == cpu_pkg::ST_MEMORY) && (opcode == cpu_pkg::OP_STORE);
      // low for the one cycle after a retire
      io_stall <= !retire;
    end
  end

  // ##########################################################
  // pc and instruction register
  // ##########################################################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (state == cpu_pkg::ST_DECODE) begin
      pc <= (opcode == cpu_pkg::OP_JUMP) ? jmp_target : pc + 1'b1;
    end else if ((state == cpu_pkg::ST_EXECUTE) && (opcode == cpu_pkg::OP_BEQ) &&
                 branch_equal) begin
      // pc already holds pc+1 here
      pc <= pc + imm[`CPU_PC_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if ((state == cpu_pkg::ST_FETCH) && inst_valid) begin
      ir <= inst_data;
    end
  end

endmodule

// ==== src/cpu_pkg.sv ====
/*
  shared types of the core
  opcodes, FSM states, ALU operations
*/
package cpu_pkg;

  // ##########################################################
  // instruction opcodes
  // ##########################################################
  // 110 and 111 are unused and retire as no-ops
  typedef enum logic [2:0] {
    OP_ARITH  = 3'b000,
    OP_CMPMUL = 3'b001,
    OP_LOAD   = 3'b010,
    OP_STORE  = 3'b011,
    OP_BEQ    = 3'b100,
    OP_JUMP   = 3'b101
  } opcode_e;

  // ##########################################################
  // control FSM
  // ##########################################################
  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_MEMORY,
    ST_WRITEBACK
  } state_e;

  // opcode and func folded into one ALU select
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_MUL
  } alu_op_e;

endpackage

// ==== src/cpu_consts.svh ====
/*
  widths of the 16-bit multicycle core
  instruction word field positions
*/
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ##########################################################
// datapath widths
// ##########################################################
// data word and register width
`define CPU_DATA_W     16
// pc and memory word address
`define CPU_PC_W       11
// register file size and index width
`define CPU_REG_CNT    16
`define CPU_REG_IDX_W  4

// ##########################################################
// instruction word fields
// ##########################################################
// opcode in the top three bits
`define CPU_OP_MSB     15
`define CPU_OP_LSB     13
// low bit of each 4-bit register field
`define CPU_RS_LSB     9
`define CPU_RT_LSB     5
`define CPU_RD_LSB     1
// signed immediate sits in the low bits
`define CPU_IMM_W      5
// jump target is 11 bits starting here
`define CPU_JMP_LSB    1

`endif
